// ==== verilog/cache_geom_pkg.sv ====
// cache geometry
// address split, line layout, way metadata
`default_nettype none

package cache_geom_pkg;

    // data word and line shape
    localparam int word_w         = 32;
    localparam int words_per_line = 4;
    localparam int line_w         = word_w * words_per_line;

    // organisation, two ways over four sets
    localparam int num_ways = 2;
    localparam int num_sets = 4;

    // address field widths, 30-bit word address
    localparam int offset_w = 2;
    localparam int set_w    = 2;
    localparam int tag_w    = 26;

    typedef logic [word_w-1:0]   word_t;
    typedef logic [tag_w-1:0]    tag_t;
    typedef logic [set_w-1:0]    set_t;
    typedef logic [offset_w-1:0] offset_t;

    // processor word address, tag in the top bits
    typedef struct packed {
        tag_t    tag;
        set_t    set;
        offset_t offset;
    } proc_addr_t;

    // line address as seen by memory
    typedef struct packed {
        tag_t tag;
        set_t set;
    } line_addr_t;

    // one line, flat for memory transfer or split into words
    typedef union packed {
        logic [line_w-1:0]                flat;
        word_t [words_per_line-1:0]       words;
    } cache_line_u;

    // per-way state kept alongside the data
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } way_meta_t;

endpackage

`default_nettype wire

// ==== verilog/cache_bus_pkg.sv ====
// cache port and controller types
`default_nettype none

package cache_bus_pkg;

    // processor side request, held while stalled
    typedef struct packed {
        logic                      read;
        logic                      write;
        cache_geom_pkg::proc_addr_t addr;
        cache_geom_pkg::word_t     wdata;
    } proc_req_t;

    // memory side request, one line per transfer
    typedef struct packed {
        logic                       read;
        logic                       write;
        cache_geom_pkg::line_addr_t  addr;
        cache_geom_pkg::cache_line_u wdata;
    } mem_req_t;

    // miss FSM states
    // request covers idle, hits and miss detection
    typedef enum logic [1:0] {
        request   = 2'd0,
        read_mem  = 2'd1,
        write_mem = 2'd2
    } ctrl_state_e;

    // lookup result for the current request
    typedef struct packed {
        logic                    hit0;
        logic                    hit1;
        cache_geom_pkg::set_t    set;
        cache_geom_pkg::offset_t offset;
        cache_geom_pkg::word_t   hit_word;
    } lookup_t;

endpackage

`default_nettype wire

// ==== verilog/cache_lookup.sv ====
// tag compare and hit word select
`timescale 1ns/10ps
`default_nettype none

module cache_lookup (
    input  cache_bus_pkg::proc_req_t                                  proc_req,
    input  cache_geom_pkg::way_meta_t   [cache_geom_pkg::num_ways-1:0] meta,
    input  cache_geom_pkg::cache_line_u [cache_geom_pkg::num_ways-1:0] lines,
    output cache_bus_pkg::lookup_t                                    look
);

    // address fields of the current request
    cache_geom_pkg::tag_t    req_tag;
    cache_geom_pkg::set_t    req_set;
    cache_geom_pkg::offset_t req_offset;

    // per-way match, only valid ways count
    logic match0;
    logic match1;

    // candidate words from both ways
    cache_geom_pkg::word_t word0;
    cache_geom_pkg::word_t word1;

    assign req_tag    = proc_req.addr.tag;
    assign req_set    = proc_req.addr.set;
    assign req_offset = proc_req.addr.offset;

    // full 26-bit tag compare
    assign match0 = meta[0].valid && (meta[0].tag == req_tag);
    assign match1 = meta[1].valid && (meta[1].tag == req_tag);

    // word view of the union picks the offset
    assign word0 = lines[0].words[req_offset];
    assign word1 = lines[1].words[req_offset];

    always_comb begin
        look.hit0   = match0;
        look.hit1   = match1;
        look.set    = req_set;
        look.offset = req_offset;
        // a tag lives in at most one way of a set
        if (match1) begin
            look.hit_word = word1;
        end else begin
            look.hit_word = word0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cache_store.sv ====
// cache tag, state and data storage
`timescale 1ns/10ps
`default_nettype none

module cache_store (
    input  logic                                                      clk,
    input  logic                                                      proc_reset,
    input  cache_geom_pkg::set_t                                      set,
    // write hit command
    input  logic                                                      wr_hit,
    input  logic                                                      hit_way,
    input  cache_geom_pkg::offset_t                                   wr_offset,
    input  cache_geom_pkg::word_t                                     wdata,
    // fill command
    input  logic                                                      fill,
    input  cache_geom_pkg::tag_t                                      fill_tag,
    input  cache_geom_pkg::cache_line_u                               fill_line,
    input  logic                                                      fill_dirty,
    // addressed set, both ways
    output cache_geom_pkg::way_meta_t   [cache_geom_pkg::num_ways-1:0] meta,
    output cache_geom_pkg::cache_line_u [cache_geom_pkg::num_ways-1:0] lines
);

    // control state per set and way
    logic [cache_geom_pkg::num_ways-1:0] valid_q [cache_geom_pkg::num_sets];
    logic [cache_geom_pkg::num_ways-1:0] dirty_q [cache_geom_pkg::num_sets];

    // payload arrays
    cache_geom_pkg::tag_t        tag_q  [cache_geom_pkg::num_sets][cache_geom_pkg::num_ways];
    cache_geom_pkg::cache_line_u data_q [cache_geom_pkg::num_sets][cache_geom_pkg::num_ways];

    // stored word under the write hit
    cache_geom_pkg::word_t old_word;
    logic                  word_changed;

    assign old_word     = data_q[set][hit_way].words[wr_offset];
    assign word_changed = (old_word != wdata);

    // valid and dirty bits
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            for (int s = 0; s < cache_geom_pkg::num_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (fill) begin
            // way 0 ages into way 1, new line becomes mru
            valid_q[set][1] <= valid_q[set][0];
            dirty_q[set][1] <= dirty_q[set][0];
            valid_q[set][0] <= 1'b1;
            dirty_q[set][0] <= fill_dirty;
        end else if (wr_hit && word_changed) begin
            // unchanged word leaves the line clean
            dirty_q[set][hit_way] <= 1'b1;
        end
    end

    // tags and line data
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[set][1]  <= tag_q[set][0];
            data_q[set][1] <= data_q[set][0];
            tag_q[set][0]  <= fill_tag;
            data_q[set][0] <= fill_line;
        end else if (wr_hit) begin
            data_q[set][hit_way].words[wr_offset] <= wdata;
        end
    end

    // read views for the addressed set
    always_comb begin
        for (int w = 0; w < cache_geom_pkg::num_ways; w++) begin
            meta[w].valid = valid_q[set][w];
            meta[w].dirty = dirty_q[set][w];
            meta[w].tag   = tag_q[set][w];
            lines[w]      = data_q[set][w];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cache_ctrl.sv ====
// miss FSM and memory port
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl (
    input  logic                        clk,
    input  logic                        proc_reset,
    input  cache_bus_pkg::proc_req_t    proc_req,
    input  cache_bus_pkg::lookup_t      look,
    // way 1 of the addressed set
    input  cache_geom_pkg::way_meta_t   victim_meta,
    input  cache_geom_pkg::cache_line_u victim_line,
    // memory response
    input  cache_geom_pkg::cache_line_u mem_rdata,
    input  logic                        mem_ready,
    output cache_bus_pkg::mem_req_t     mem_req,
    output logic                        proc_stall,
    output cache_geom_pkg::word_t       proc_rdata,
    // store commands
    output logic                        wr_hit,
    output logic                        hit_way,
    output logic                        fill,
    output cache_geom_pkg::tag_t        fill_tag,
    output cache_geom_pkg::cache_line_u fill_line,
    output logic                        fill_dirty
);

    cache_bus_pkg::ctrl_state_e state_q;
    cache_bus_pkg::ctrl_state_e state_d;

    logic access;
    logic hit;
    logic write_back;

    // line addresses of the request and of the victim
    cache_geom_pkg::line_addr_t req_line_addr;
    cache_geom_pkg::line_addr_t victim_line_addr;

    assign access     = proc_req.read || proc_req.write;
    assign hit        = look.hit0 || look.hit1;
    // only a valid dirty victim needs writing back
    assign write_back = victim_meta.valid && victim_meta.dirty;

    assign req_line_addr.tag    = proc_req.addr.tag;
    assign req_line_addr.set    = look.set;
    assign victim_line_addr.tag = victim_meta.tag;
    assign victim_line_addr.set = look.set;

    assign hit_way = look.hit1;

    // read data mux, fetched word while filling
    assign proc_rdata = (state_q == cache_bus_pkg::read_mem) ?
                        mem_rdata.words[look.offset] : look.hit_word;

    // fill payload, write word merged into the fetched line
    always_comb begin
        fill_line = mem_rdata;
        if (proc_req.write) begin
            fill_line.words[look.offset] = proc_req.wdata;
        end
    end
    assign fill_tag   = proc_req.addr.tag;
    // write-miss line differs from memory
    assign fill_dirty = proc_req.write;

    // next state and outputs
    always_comb begin
        state_d    = state_q;
        mem_req    = '0;
        proc_stall = 1'b0;
        wr_hit     = 1'b0;
        fill       = 1'b0;
        case (state_q)
            cache_bus_pkg::request: begin
                if (access && hit) begin
                    // hits finish here, no stall
                    wr_hit = proc_req.write;
                end else if (access) begin
                    proc_stall = 1'b1;
                    if (write_back) begin
                        mem_req.write = 1'b1;
                        mem_req.addr  = victim_line_addr;
                        mem_req.wdata = victim_line;
                        state_d       = cache_bus_pkg::write_mem;
                    end else begin
                        mem_req.read = 1'b1;
                        mem_req.addr = req_line_addr;
                        state_d      = cache_bus_pkg::read_mem;
                    end
                end
            end
            cache_bus_pkg::write_mem: begin
                proc_stall = 1'b1;
                if (mem_ready) begin
                    // victim accepted, fetch starts now
                    mem_req.read = 1'b1;
                    mem_req.addr = req_line_addr;
                    state_d      = cache_bus_pkg::read_mem;
                end else begin
                    mem_req.write = 1'b1;
                    mem_req.addr  = victim_line_addr;
                    mem_req.wdata = victim_line;
                end
            end
            cache_bus_pkg::read_mem: begin
                // request held through the ready cycle
                mem_req.read = 1'b1;
                mem_req.addr = req_line_addr;
                proc_stall   = !mem_ready;
                if (mem_ready) begin
                    fill    = 1'b1;
                    state_d = cache_bus_pkg::request;
                end
            end
            default: begin
                state_d = cache_bus_pkg::request;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state_q <= cache_bus_pkg::request;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cache_top.sv ====
// two-way write-back data cache
`timescale 1ns/10ps
`default_nettype none

module cache_top (
    input  logic                        clk,
    input  logic                        proc_reset,
    // processor port
    input  cache_bus_pkg::proc_req_t    proc_req,
    output cache_geom_pkg::word_t       proc_rdata,
    output logic                        proc_stall,
    // memory port
    output cache_bus_pkg::mem_req_t     mem_req,
    input  cache_geom_pkg::cache_line_u mem_rdata,
    input  logic                        mem_ready
);

    cache_bus_pkg::lookup_t look;

    // addressed set from the store
    cache_geom_pkg::way_meta_t   [cache_geom_pkg::num_ways-1:0] meta;
    cache_geom_pkg::cache_line_u [cache_geom_pkg::num_ways-1:0] lines;

    // store commands
    logic                        wr_hit;
    logic                        hit_way;
    logic                        fill;
    cache_geom_pkg::tag_t        fill_tag;
    cache_geom_pkg::cache_line_u fill_line;
    logic                        fill_dirty;

    cache_lookup u_cache_lookup (
        .proc_req (proc_req),
        .meta     (meta),
        .lines    (lines),
        .look     (look)
    );

    // set index taken straight from the address
    cache_store u_cache_store (
        .clk        (clk),
        .proc_reset (proc_reset),
        .set        (proc_req.addr.set),
        .wr_hit     (wr_hit),
        .hit_way    (hit_way),
        .wr_offset  (proc_req.addr.offset),
        .wdata      (proc_req.wdata),
        .fill       (fill),
        .fill_tag   (fill_tag),
        .fill_line  (fill_line),
        .fill_dirty (fill_dirty),
        .meta       (meta),
        .lines      (lines)
    );

    // way 1 is always the victim
    cache_ctrl u_cache_ctrl (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .proc_req    (proc_req),
        .look        (look),
        .victim_meta (meta[1]),
        .victim_line (lines[1]),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .mem_req     (mem_req),
        .proc_stall  (proc_stall),
        .proc_rdata  (proc_rdata),
        .wr_hit      (wr_hit),
        .hit_way     (hit_way),
        .fill        (fill),
        .fill_tag    (fill_tag),
        .fill_line   (fill_line),
        .fill_dirty  (fill_dirty)
    );

endmodule

`default_nettype wire

// ==== sim/mem_model.sv ====
// behavioral line memory
`timescale 1ns/10ps
`default_nettype none

module mem_model #(
    parameter int latency = 3
) (
    input  logic                        clk,
    input  logic                        proc_reset,
    input  cache_bus_pkg::mem_req_t     mem_req,
    output cache_geom_pkg::cache_line_u mem_rdata,
    output logic                        mem_ready
);

    // lines written back so far, keyed by line address
    logic [cache_geom_pkg::line_w-1:0] lines_q [logic [27:0]];

    int unsigned wait_q;
    logic [27:0] line_key;

    assign line_key = mem_req.addr;

    // initial contents, every bit of the word address shows up
    function automatic cache_geom_pkg::word_t pattern_word(input logic [29:0] waddr);
        return {waddr, 2'b11} ^ 32'h9e3779b9;
    endfunction

    function automatic cache_geom_pkg::cache_line_u fetch_line(input logic [27:0] key);
        cache_geom_pkg::cache_line_u line;
        if (lines_q.exists(key)) begin
            line.flat = lines_q[key];
        end else begin
            for (int w = 0; w < cache_geom_pkg::words_per_line; w++) begin
                line.words[w[1:0]] = pattern_word({key, w[1:0]});
            end
        end
        return line;
    endfunction

    // count held request cycles, then one ready pulse
    always @(posedge clk) begin
        if (proc_reset) begin
            wait_q    <= 0;
            mem_ready <= 1'b0;
            mem_rdata <= '0;
        end else begin
            mem_ready <= 1'b0;
            if ((mem_req.read || mem_req.write) && !mem_ready) begin
                if (wait_q == latency - 1) begin
                    wait_q    <= 0;
                    mem_ready <= 1'b1;
                    // write data is taken while still held
                    if (mem_req.write) begin
                        lines_q[line_key] = mem_req.wdata.flat;
                    end else begin
                        mem_rdata <= fetch_line(line_key);
                    end
                end else begin
                    wait_q <= wait_q + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_cache_top.sv ====
// cache testbench with shadow reference
`timescale 1ns/10ps
`default_nettype none

module tb_cache_top;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 16;
    localparam int idle_cycles  = 8;
    localparam int mem_latency  = 3;
    localparam int num_directed = 11;
    localparam int num_random   = 400;
    localparam int num_accesses = num_directed + num_random;
    // worst case per access is write back plus fetch
    localparam int watchdog_cycles = reset_cycles + idle_cycles + 8 +
                                     num_accesses * (2 * mem_latency + 4);

    // expected outcome of one access
    typedef struct packed {
        logic                        hit;
        logic                        write_back;
        cache_geom_pkg::line_addr_t  victim_addr;
        cache_geom_pkg::cache_line_u victim_data;
        cache_geom_pkg::line_addr_t  req_addr;
        cache_geom_pkg::word_t       rdata;
    } expect_t;

    logic                        clk;
    logic                        proc_reset;
    cache_bus_pkg::proc_req_t    proc_req;
    cache_geom_pkg::word_t       proc_rdata;
    logic                        proc_stall;
    cache_bus_pkg::mem_req_t     mem_req;
    cache_geom_pkg::cache_line_u mem_rdata;
    logic                        mem_ready;

    // shadow cache, way 0 is the most recent fill
    logic                 sh_valid [cache_geom_pkg::num_sets][cache_geom_pkg::num_ways];
    logic                 sh_dirty [cache_geom_pkg::num_sets][cache_geom_pkg::num_ways];
    cache_geom_pkg::tag_t sh_tag   [cache_geom_pkg::num_sets][cache_geom_pkg::num_ways];
    // architectural memory as the processor sees it
    cache_geom_pkg::word_t shadow_mem [logic [29:0]];

    logic [31:0] lcg_state;
    expect_t     exp_r;
    logic        active;
    logic        checking;
    int          cyc;
    string       test_name;

    cache_top u_cache_top (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_req   (proc_req),
        .proc_rdata (proc_rdata),
        .proc_stall (proc_stall),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    mem_model #(
        .latency (mem_latency)
    ) u_mem_model (
        .clk        (clk),
        .proc_reset (proc_reset),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input cache_geom_pkg::word_t expected,
                              input cache_geom_pkg::word_t actual);
        if (expected !== actual) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_line(input string name, input cache_geom_pkg::cache_line_u expected,
                              input cache_geom_pkg::cache_line_u actual);
        if (expected !== actual) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, name,
                     expected.flat, actual.flat);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input cache_geom_pkg::line_addr_t expected,
                              input cache_geom_pkg::line_addr_t actual);
        if (expected !== actual) begin
            $display("Fail %s %s: expected %h, actual %h", test_name, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("Fail %s %s: expected %b, actual %b", test_name, name, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // untouched memory, whole word address folded in
    function automatic cache_geom_pkg::word_t pattern_word(input logic [29:0] waddr);
        return {waddr, 2'b11} ^ 32'h9e3779b9;
    endfunction

    function automatic cache_geom_pkg::word_t mem_word(input logic [29:0] waddr);
        if (shadow_mem.exists(waddr)) begin
            return shadow_mem[waddr];
        end
        return pattern_word(waddr);
    endfunction

    // tags that also differ in the top tag bit
    function automatic cache_geom_pkg::tag_t pick_tag(input logic [1:0] sel);
        case (sel)
            2'd0: return 26'h0000000;
            2'd1: return 26'h0000001;
            2'd2: return 26'h2000000;
            default: return 26'h2000001;
        endcase
    endfunction

    // reference: hit, victim write back and read word
    function automatic expect_t predict_access(input cache_geom_pkg::proc_addr_t addr);
        expect_t              e;
        cache_geom_pkg::set_t s;
        s = addr.set;
        e = '0;
        e.hit = (sh_valid[s][0] && sh_tag[s][0] == addr.tag) ||
                (sh_valid[s][1] && sh_tag[s][1] == addr.tag);
        // way 1 goes out on a miss
        e.write_back      = !e.hit && sh_valid[s][1] && sh_dirty[s][1];
        e.victim_addr.tag = sh_tag[s][1];
        e.victim_addr.set = s;
        for (int w = 0; w < cache_geom_pkg::words_per_line; w++) begin
            e.victim_data.words[w[1:0]] = mem_word({sh_tag[s][1], s, w[1:0]});
        end
        e.req_addr.tag = addr.tag;
        e.req_addr.set = s;
        e.rdata        = mem_word(addr);
        return e;
    endfunction

    task automatic update_shadow(input logic wr, input cache_geom_pkg::proc_addr_t addr,
                                 input cache_geom_pkg::word_t wdata);
        cache_geom_pkg::set_t s;
        logic                 hit0;
        logic                 hit1;
        s    = addr.set;
        hit0 = sh_valid[s][0] && sh_tag[s][0] == addr.tag;
        hit1 = sh_valid[s][1] && sh_tag[s][1] == addr.tag;
        if (hit0 || hit1) begin
            // only a changed word dirties the line
            if (wr && mem_word(addr) != wdata) begin
                sh_dirty[s][hit1] = 1'b1;
            end
        end else begin
            sh_valid[s][1] = sh_valid[s][0];
            sh_dirty[s][1] = sh_dirty[s][0];
            sh_tag[s][1]   = sh_tag[s][0];
            sh_valid[s][0] = 1'b1;
            sh_dirty[s][0] = wr;
            sh_tag[s][0]   = addr.tag;
        end
        if (wr) begin
            shadow_mem[addr] = wdata;
        end
    endtask

    // one access, held until the stall drops
    task automatic run_access(input logic rd, input logic wr,
                              input cache_geom_pkg::proc_addr_t addr,
                              input cache_geom_pkg::word_t wdata);
        @(posedge clk);
        #1;
        exp_r          = predict_access(addr);
        proc_req.read  = rd;
        proc_req.write = wr;
        proc_req.addr  = addr;
        proc_req.wdata = wdata;
        active         = 1'b1;
        do @(negedge clk); while (proc_stall);
        update_shadow(wr, addr, wdata);
    endtask

    task automatic run_directed();
        cache_geom_pkg::proc_addr_t a;
        cache_geom_pkg::proc_addr_t b;
        cache_geom_pkg::proc_addr_t c;
        cache_geom_pkg::proc_addr_t d;
        a = '{tag: pick_tag(2'd0), set: 2'd1, offset: 2'd1};
        b = '{tag: pick_tag(2'd1), set: 2'd1, offset: 2'd2};
        c = '{tag: pick_tag(2'd2), set: 2'd1, offset: 2'd3};
        d = '{tag: pick_tag(2'd3), set: 2'd1, offset: 2'd0};
        run_access(1'b1, 1'b0, a, '0);
        run_access(1'b1, 1'b0, a, '0);
        // same value written back, line stays clean
        run_access(1'b0, 1'b1, a, mem_word(a));
        run_access(1'b1, 1'b0, b, '0);
        // clean victim a, no write back
        run_access(1'b1, 1'b0, c, '0);
        run_access(1'b0, 1'b1, c, 32'h0badcafe);
        run_access(1'b1, 1'b0, d, '0);
        // write miss evicts dirty c
        run_access(1'b0, 1'b1, a, 32'h12345678);
        run_access(1'b1, 1'b0, b, '0);
        // merged write-miss line goes out dirty
        run_access(1'b1, 1'b0, c, '0);
        run_access(1'b1, 1'b0, a, '0);
    endtask

    task automatic run_random();
        logic [31:0]                r;
        cache_geom_pkg::proc_addr_t addr;
        cache_geom_pkg::word_t      wdata;
        for (int i = 0; i < num_random; i++) begin
            r           = next_rand();
            addr.tag    = pick_tag(r[31:30]);
            addr.set    = r[29:28];
            addr.offset = r[27:26];
            // a quarter of the writes repeat the stored word
            if (r[24:23] == 2'd0) begin
                wdata = mem_word(addr);
            end else begin
                wdata = next_rand();
            end
            run_access(!r[25], r[25], addr, wdata);
        end
    endtask

    // compare at mid cycle, outputs settled
    always @(negedge clk) begin
        if (checking) begin
            if (!active) begin
                check_bit("idle stall", 1'b0, proc_stall);
                check_bit("idle mem read", 1'b0, mem_req.read);
                check_bit("idle mem write", 1'b0, mem_req.write);
            end else begin
                if (cyc == 0) begin
                    if (exp_r.hit) begin
                        check_bit("hit stall", 1'b0, proc_stall);
                        check_bit("hit mem read", 1'b0, mem_req.read);
                        check_bit("hit mem write", 1'b0, mem_req.write);
                    end else if (exp_r.write_back) begin
                        check_bit("miss stall", 1'b1, proc_stall);
                        check_bit("write back", 1'b1, mem_req.write);
                        check_addr("victim addr", exp_r.victim_addr, mem_req.addr);
                        check_line("victim data", exp_r.victim_data, mem_req.wdata);
                    end else begin
                        check_bit("miss stall", 1'b1, proc_stall);
                        check_bit("fetch read", 1'b1, mem_req.read);
                        check_bit("no write back", 1'b0, mem_req.write);
                    end
                end
                if (!exp_r.write_back) begin
                    check_bit("stray write", 1'b0, mem_req.write);
                end
                if (mem_req.read) begin
                    check_addr("fetch addr", exp_r.req_addr, mem_req.addr);
                end
                if (!proc_stall && proc_req.read) begin
                    check_word("read data", exp_r.rdata, proc_rdata);
                end
                if (proc_stall) begin
                    cyc = cyc + 1;
                end else begin
                    cyc = 0;
                end
            end
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout: run did not end within %0d cycles", watchdog_cycles);
        abort_run();
    end

    initial begin
        proc_reset = 1'b1;
        proc_req   = '0;
        active     = 1'b0;
        checking   = 1'b0;
        cyc        = 0;
        exp_r      = '0;
        lcg_state  = 32'h52410ebc;
        test_name  = "reset idle";
        for (int s = 0; s < cache_geom_pkg::num_sets; s++) begin
            for (int w = 0; w < cache_geom_pkg::num_ways; w++) begin
                sh_valid[s[1:0]][w[0]] = 1'b0;
                sh_dirty[s[1:0]][w[0]] = 1'b0;
                sh_tag[s[1:0]][w[0]]   = '0;
            end
        end
        repeat (reset_cycles) @(posedge clk);
        #1;
        proc_reset = 1'b0;
        checking   = 1'b1;
        repeat (idle_cycles) @(posedge clk);
        test_name = "directed";
        run_directed();
        test_name = "random mix";
        run_random();
        @(posedge clk);
        #1;
        proc_req  = '0;
        active    = 1'b0;
        test_name = "final idle";
        repeat (4) @(posedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cache_top.f ====
verilog/cache_geom_pkg.sv
verilog/cache_bus_pkg.sv
verilog/cache_lookup.sv
verilog/cache_store.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
sim/mem_model.sv
sim/tb_cache_top.sv

// ==== Makefile ====
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP       ?= tb_cache_top
FILELIST  ?= cache_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
